// File: husky_defs.svh
`ifndef HUSKY_DEFS_SVH
`define HUSKY_DEFS_SVH

// Register bus geometry
`define BYTECNT_SIZE 7
`define REG_DATA_W 8
`define REG_ADDR_W 8

`define NUM_ERR_SRC 3  // Fifo, xadc and trace error sources

// Register map
`define TARGET_CTRL_ADDR 8'h10
`define TARGET_OUT_ADDR 8'h11
`define ERROR_STATUS_ADDR 8'h12
`define FLASH_PERIOD_ADDR 8'h13

// TARGET_CTRL bit positions
`define TGT_CTRL_PWROFF_BIT 0
`define TGT_CTRL_AVRPROG_BIT 1

// Enables sit this far above their drive bits in TARGET_OUT
`define TGT_OUT_OE_OFS 4

`define FLASH_PERIOD_DEFAULT 1000  // LED half-period in clocks

`endif

// File: husky_pkg.sv
`include "husky_defs.svh"

package husky_pkg;

   // Register bus fields
   typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
   typedef logic [`REG_DATA_W-1:0] reg_data_t;

   // Byte index inside a multi-byte register
   typedef logic [`BYTECNT_SIZE-1:0] bytecnt_t;

   // One sticky bit per external error source
   typedef logic [`NUM_ERR_SRC-1:0] err_flags_t;

   // Half-period of the red LED flash, in clocks
   typedef logic [15:0] flash_period_t;

endpackage

// File: reg_bus_if.sv
interface reg_bus_if;
   import husky_pkg::*;

   reg_addr_t reg_address;
   bytecnt_t  reg_bytecnt;
   reg_data_t reg_write_data;
   logic      reg_read;   // One-cycle pulse
   logic      reg_write;  // One-cycle pulse

   modport host (
      output reg_address,
      output reg_bytecnt,
      output reg_write_data,
      output reg_read,
      output reg_write
   );

   modport slave (
      input reg_address,
      input reg_bytecnt,
      input reg_write_data,
      input reg_read,
      input reg_write
   );

endinterface

// File: usb_reg_main.sv
module usb_reg_main (
   input  logic                 clk_usb_buf,
   input  logic                 rst_i,
   input  husky_pkg::reg_addr_t usb_addr_i,
   input  husky_pkg::reg_data_t usb_data_i,
   input  logic                 usb_rdn_i,
   input  logic                 usb_wrn_i,
   input  logic                 usb_cen_i,
   input  logic                 usb_alen_i,
   input  husky_pkg::reg_data_t read_data_i,
   output husky_pkg::reg_data_t usb_data_o,
   output logic                 usb_data_oe_o,
   reg_bus_if.host              bus
);
   import husky_pkg::*;

   reg_addr_t addr_q;
   reg_data_t data_q;
   logic      rdn_q;
   logic      wrn_q;
   logic      cen_q;
   logic      alen_q;
   logic      rdn_qq;
   logic      wrn_qq;
   logic      rd_fall;
   logic      rd_rise;
   logic      wr_rise;
   logic      addr_latch;

   // Address and data bus sample stage
   always_ff @(posedge clk_usb_buf) begin
      addr_q <= usb_addr_i;
      data_q <= usb_data_i;
   end

   // Strobes come in through the same stage, plus one more for edges
   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         rdn_q  <= 1'b1;  // All strobes idle high
         wrn_q  <= 1'b1;
         cen_q  <= 1'b1;
         alen_q <= 1'b1;
         rdn_qq <= 1'b1;
         wrn_qq <= 1'b1;
      end else begin
         rdn_q  <= usb_rdn_i;
         wrn_q  <= usb_wrn_i;
         cen_q  <= usb_cen_i;
         alen_q <= usb_alen_i;
         rdn_qq <= rdn_q;
         wrn_qq <= wrn_q;
      end
   end

   assign rd_fall    = ~rdn_q & rdn_qq & ~cen_q;
   assign rd_rise    = rdn_q & ~rdn_qq;         // End of a read byte
   assign wr_rise    = wrn_q & ~wrn_qq & ~cen_q;
   assign addr_latch = ~cen_q & ~alen_q;

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         bus.reg_address <= '0;
         bus.reg_bytecnt <= '0;
         bus.reg_read    <= 1'b0;
         bus.reg_write   <= 1'b0;
      end else begin
         bus.reg_read  <= rd_fall;
         bus.reg_write <= wr_rise;
         if (addr_latch) begin
            bus.reg_address <= addr_q;
            bus.reg_bytecnt <= '0;
         end else if (bus.reg_write || rd_rise) begin
            // Next byte of a multi-byte register
            bus.reg_bytecnt <= bus.reg_bytecnt + 1'b1;
         end
      end
   end

   // Write byte travels with the write pulse
   always_ff @(posedge clk_usb_buf) begin
      if (wr_rise) begin
         bus.reg_write_data <= data_q;
      end
   end

   assign usb_data_oe_o = ~rdn_q & ~cen_q;  // Drive only during a sampled read
   assign usb_data_o    = read_data_i;

endmodule

// File: reg_target_io.sv
`include "husky_defs.svh"

module reg_target_io (
   input  logic                 clk_usb_buf,
   input  logic                 rst_i,
   input  logic                 avr_rst_i,
   input  logic                 sam_mosi_i,
   input  logic                 sam_spck_i,
   input  logic                 target_miso_i,
   reg_bus_if.slave             bus,
   output husky_pkg::reg_data_t read_data_o,
   output logic                 target_poweron_o,
   output logic                 target_nrst_o,
   output logic                 target_nrst_oe_o,
   output logic                 target_pdid_o,
   output logic                 target_pdid_oe_o,
   output logic                 target_pdic_o,
   output logic                 target_pdic_oe_o,
   output logic                 target_mosi_o,
   output logic                 target_mosi_oe_o,
   output logic                 target_sck_o,
   output logic                 target_sck_oe_o,
   output logic                 sam_miso_o,
   output logic                 sam_miso_oe_o
);
   import husky_pkg::*;

   logic       power_off;
   logic       avrprog_en;
   logic [2:0] pin_drive;  // nRST, PDID, PDIC
   logic [2:0] pin_en;
   logic       byte0_write;

   assign byte0_write = bus.reg_write && (bus.reg_bytecnt == '0);

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         power_off  <= 1'b1;  // Target starts unpowered
         avrprog_en <= 1'b0;
         pin_drive  <= '0;
         pin_en     <= '0;
      end else if (byte0_write) begin
         if (bus.reg_address == `TARGET_CTRL_ADDR) begin
            power_off  <= bus.reg_write_data[`TGT_CTRL_PWROFF_BIT];
            avrprog_en <= bus.reg_write_data[`TGT_CTRL_AVRPROG_BIT];
         end
         if (bus.reg_address == `TARGET_OUT_ADDR) begin
            pin_drive <= bus.reg_write_data[2:0];
            pin_en    <= bus.reg_write_data[`TGT_OUT_OE_OFS +: 3];
         end
      end
   end

   always_comb begin
      read_data_o = '0;
      if (bus.reg_address == `TARGET_CTRL_ADDR) begin
         read_data_o[`TGT_CTRL_PWROFF_BIT]  = power_off;
         read_data_o[`TGT_CTRL_AVRPROG_BIT] = avrprog_en;
      end else if (bus.reg_address == `TARGET_OUT_ADDR) begin
         read_data_o[2:0]                 = pin_drive;
         read_data_o[`TGT_OUT_OE_OFS +: 3] = pin_en;
      end
   end

   assign target_poweron_o = ~power_off;

   // Power-off floats every target pin
   assign target_nrst_o    = avrprog_en ? avr_rst_i : pin_drive[0];
   assign target_nrst_oe_o = ~power_off & (avrprog_en | pin_en[0]);
   assign target_pdid_o    = pin_drive[1];
   assign target_pdid_oe_o = ~power_off & pin_en[1];
   assign target_pdic_o    = pin_drive[2];
   assign target_pdic_oe_o = ~power_off & pin_en[2];

   // AVR programming SPI path from the SAM
   assign target_mosi_o    = sam_mosi_i;
   assign target_mosi_oe_o = ~power_off & avrprog_en;
   assign target_sck_o     = sam_spck_i;
   assign target_sck_oe_o  = ~power_off & avrprog_en;
   assign sam_miso_o       = target_miso_i;
   assign sam_miso_oe_o    = avrprog_en;  // SAM side, independent of target power

endmodule

// File: reg_status_led.sv
`include "husky_defs.svh"

module reg_status_led (
   input  logic                   clk_usb_buf,
   input  logic                   rst_i,
   input  husky_pkg::err_flags_t  error_flags_i,
   input  logic                   pll_status_i,
   reg_bus_if.slave               bus,
   output husky_pkg::reg_data_t   read_data_o,
   output logic                   led_adc_o,
   output logic                   led_glitch_o
);
   import husky_pkg::*;

   err_flags_t    err_flags;
   err_flags_t    err_clear;
   flash_period_t flash_period;
   flash_period_t flash_cnt;
   logic          flash_level;
   logic          error_any;
   logic          byte0_write;

   assign byte0_write = bus.reg_write && (bus.reg_bytecnt == '0);
   assign err_clear   = (byte0_write && bus.reg_address == `ERROR_STATUS_ADDR) ?
                        bus.reg_write_data[`NUM_ERR_SRC-1:0] : '0;
   assign error_any   = |err_flags;

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         err_flags    <= '0;
         flash_period <= flash_period_t'(`FLASH_PERIOD_DEFAULT);
      end else begin
         err_flags <= (err_flags & ~err_clear) | error_flags_i;  // New error beats clear
         if (bus.reg_write && bus.reg_address == `FLASH_PERIOD_ADDR) begin
            if (bus.reg_bytecnt == 0) flash_period[7:0]  <= bus.reg_write_data;
            if (bus.reg_bytecnt == 1) flash_period[15:8] <= bus.reg_write_data;
         end
      end
   end

   // Flash only runs while an error is pending
   always_ff @(posedge clk_usb_buf) begin
      if (rst_i || !error_any) begin
         flash_cnt   <= '0;
         flash_level <= 1'b0;
      end else if (flash_cnt >= flash_period - 1'b1) begin
         flash_cnt   <= '0;
         flash_level <= ~flash_level;
      end else begin
         flash_cnt <= flash_cnt + 1'b1;
      end
   end

   always_comb begin
      read_data_o = '0;
      if (bus.reg_address == `ERROR_STATUS_ADDR) begin
         read_data_o[`NUM_ERR_SRC-1:0] = err_flags;
      end else if (bus.reg_address == `FLASH_PERIOD_ADDR) begin
         if (bus.reg_bytecnt == 0) read_data_o = flash_period[7:0];
         if (bus.reg_bytecnt == 1) read_data_o = flash_period[15:8];
      end
   end

   assign led_adc_o    = error_any ? flash_level : ~pll_status_i;
   assign led_glitch_o = error_any & flash_level;

endmodule

// File: cw_husky_top.sv
module cw_husky_top (
   input  logic                  clk_usb_buf,
   input  logic                  rst_i,
   // USB host port
   input  husky_pkg::reg_addr_t  usb_addr_i,
   input  husky_pkg::reg_data_t  usb_data_i,
   input  logic                  usb_rdn_i,
   input  logic                  usb_wrn_i,
   input  logic                  usb_cen_i,
   input  logic                  usb_alen_i,
   output husky_pkg::reg_data_t  usb_data_o,
   output logic                  usb_data_oe_o,
   // Target and SAM pins
   input  logic                  avr_rst_i,
   input  logic                  sam_mosi_i,
   input  logic                  sam_spck_i,
   input  logic                  target_miso_i,
   output logic                  target_poweron_o,
   output logic                  target_nrst_o,
   output logic                  target_nrst_oe_o,
   output logic                  target_pdid_o,
   output logic                  target_pdid_oe_o,
   output logic                  target_pdic_o,
   output logic                  target_pdic_oe_o,
   output logic                  target_mosi_o,
   output logic                  target_mosi_oe_o,
   output logic                  target_sck_o,
   output logic                  target_sck_oe_o,
   output logic                  sam_miso_o,
   output logic                  sam_miso_oe_o,
   // Errors and LEDs
   input  husky_pkg::err_flags_t error_flags_i,
   input  logic                  pll_status_i,
   output logic                  led_adc_o,
   output logic                  led_glitch_o
);
   import husky_pkg::*;

   reg_data_t read_data_target;
   reg_data_t read_data_status;
   reg_data_t read_data_q;

   reg_bus_if reg_bus ();

   // Unselected blocks return zero, so a plain OR merges them
   always_ff @(posedge clk_usb_buf) begin
      read_data_q <= read_data_target | read_data_status;
   end

   usb_reg_main usb_reg_main_inst (
      .clk_usb_buf   (clk_usb_buf),
      .rst_i         (rst_i),
      .usb_addr_i    (usb_addr_i),
      .usb_data_i    (usb_data_i),
      .usb_rdn_i     (usb_rdn_i),
      .usb_wrn_i     (usb_wrn_i),
      .usb_cen_i     (usb_cen_i),
      .usb_alen_i    (usb_alen_i),
      .read_data_i   (read_data_q),
      .usb_data_o    (usb_data_o),
      .usb_data_oe_o (usb_data_oe_o),
      .bus           (reg_bus.host)
   );

   reg_target_io reg_target_io_inst (
      .clk_usb_buf      (clk_usb_buf),
      .rst_i            (rst_i),
      .avr_rst_i        (avr_rst_i),
      .sam_mosi_i       (sam_mosi_i),
      .sam_spck_i       (sam_spck_i),
      .target_miso_i    (target_miso_i),
      .bus              (reg_bus.slave),
      .read_data_o      (read_data_target),
      .target_poweron_o (target_poweron_o),
      .target_nrst_o    (target_nrst_o),
      .target_nrst_oe_o (target_nrst_oe_o),
      .target_pdid_o    (target_pdid_o),
      .target_pdid_oe_o (target_pdid_oe_o),
      .target_pdic_o    (target_pdic_o),
      .target_pdic_oe_o (target_pdic_oe_o),
      .target_mosi_o    (target_mosi_o),
      .target_mosi_oe_o (target_mosi_oe_o),
      .target_sck_o     (target_sck_o),
      .target_sck_oe_o  (target_sck_oe_o),
      .sam_miso_o       (sam_miso_o),
      .sam_miso_oe_o    (sam_miso_oe_o)
   );

   reg_status_led reg_status_led_inst (
      .clk_usb_buf   (clk_usb_buf),
      .rst_i         (rst_i),
      .error_flags_i (error_flags_i),
      .pll_status_i  (pll_status_i),
      .bus           (reg_bus.slave),
      .read_data_o   (read_data_status),
      .led_adc_o     (led_adc_o),
      .led_glitch_o  (led_glitch_o)
   );

endmodule

// File: tb_cw_husky_top.sv
`include "husky_defs.svh"

module tb_cw_husky_top;
   import husky_pkg::*;

   localparam int SEED       = 68;
   localparam int HOLD       = 8;    // Clocks per host strobe level
   localparam int WAIT_LIMIT = 200;

   logic       clk_usb_buf;
   logic       rst_i;
   reg_addr_t  usb_addr_i;
   reg_data_t  usb_data_i;
   logic       usb_rdn_i;
   logic       usb_wrn_i;
   logic       usb_cen_i;
   logic       usb_alen_i;
   reg_data_t  usb_data_o;
   logic       usb_data_oe_o;
   logic       avr_rst_i;
   logic       sam_mosi_i;
   logic       sam_spck_i;
   logic       target_miso_i;
   logic       target_poweron_o;
   logic       target_nrst_o;
   logic       target_nrst_oe_o;
   logic       target_pdid_o;
   logic       target_pdid_oe_o;
   logic       target_pdic_o;
   logic       target_pdic_oe_o;
   logic       target_mosi_o;
   logic       target_mosi_oe_o;
   logic       target_sck_o;
   logic       target_sck_oe_o;
   logic       sam_miso_o;
   logic       sam_miso_oe_o;
   err_flags_t error_flags_i;
   logic       pll_status_i;
   logic       led_adc_o;
   logic       led_glitch_o;

   // Register images as the host has written them
   reg_data_t  ctrl_img;
   reg_data_t  out_img;
   err_flags_t flags_img;
   logic       check_en;  // Pins and idle LEDs compared while set

   cw_husky_top cw_husky_top_inst (.*);

   initial begin
      clk_usb_buf = 1'b0;
      forever #2 clk_usb_buf = ~clk_usb_buf;
   end

   // Poweron in bit 12 followed by oe and value pairs for nRST, PDID, PDIC, MOSI, SCK and MISO
   function automatic logic [12:0] expected_pins(reg_data_t ctrl, reg_data_t out,
         logic avr_rst, logic mosi, logic spck, logic miso);
      logic        pwr_on;
      logic        avr_en;
      logic [12:0] pins;
      pwr_on   = ~ctrl[`TGT_CTRL_PWROFF_BIT];
      avr_en   = ctrl[`TGT_CTRL_AVRPROG_BIT];
      pins[12] = pwr_on;
      pins[11] = pwr_on & (avr_en | out[4]);
      pins[10] = avr_en ? avr_rst : out[0];  // AVR reset takes over nRST
      pins[9]  = pwr_on & out[5];
      pins[8]  = out[1];
      pins[7]  = pwr_on & out[6];
      pins[6]  = out[2];
      pins[5]  = pwr_on & avr_en;
      pins[4]  = mosi;
      pins[3]  = pwr_on & avr_en;
      pins[2]  = spck;
      pins[1]  = avr_en;                     // SAM side ignores target power
      pins[0]  = miso;
      return pins;
   endfunction

   function automatic err_flags_t expected_status(err_flags_t flags, err_flags_t clear,
         err_flags_t err_in);
      err_flags_t result;
      for (int i = 0; i < `NUM_ERR_SRC; i++) begin
         if (err_in[i]) begin
            result[i] = 1'b1;  // Set wins over a clear in the same cycle
         end else if (clear[i]) begin
            result[i] = 1'b0;
         end else begin
            result[i] = flags[i];
         end
      end
      return result;
   endfunction

   task automatic check_data(string name, reg_data_t got, reg_data_t exp);
      if (got !== exp) begin
         $display("Fail at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
         $display("SIMULATION FAILED");
         $fatal(1, "Value mismatch on %s", name);
      end
   endtask

   task automatic check_bit(string name, logic got, logic exp);
      if (got !== exp) begin
         $display("Fail at time %0t: %s is %b, expected %b", $time, name, got, exp);
         $display("SIMULATION FAILED");
         $fatal(1, "Value mismatch on %s", name);
      end
   endtask

   task automatic report_timeout(string what);
      $display("Timeout: %s did not happen within %0d clocks", what, WAIT_LIMIT);
      $display("SIMULATION FAILED");
      $fatal(1, "Timeout waiting for %s", what);
   endtask

   // Value only matters while the pin is driven
   task automatic check_pin(string name, logic oe, logic val, logic exp_oe, logic exp_val);
      check_bit({name, "_oe_o"}, oe, exp_oe);
      if (exp_oe) begin
         check_bit({name, "_o"}, val, exp_val);
      end
   endtask

   always @(posedge clk_usb_buf) begin
      logic [12:0] exp_pins;
      #1;
      if (check_en) begin
         exp_pins = expected_pins(ctrl_img, out_img, avr_rst_i, sam_mosi_i, sam_spck_i,
                                  target_miso_i);
         check_bit("target_poweron_o", target_poweron_o, exp_pins[12]);
         check_pin("target_nrst", target_nrst_oe_o, target_nrst_o, exp_pins[11], exp_pins[10]);
         check_pin("target_pdid", target_pdid_oe_o, target_pdid_o, exp_pins[9], exp_pins[8]);
         check_pin("target_pdic", target_pdic_oe_o, target_pdic_o, exp_pins[7], exp_pins[6]);
         check_pin("target_mosi", target_mosi_oe_o, target_mosi_o, exp_pins[5], exp_pins[4]);
         check_pin("target_sck", target_sck_oe_o, target_sck_o, exp_pins[3], exp_pins[2]);
         check_pin("sam_miso", sam_miso_oe_o, sam_miso_o, exp_pins[1], exp_pins[0]);
         if (flags_img == '0) begin
            check_bit("led_adc_o", led_adc_o, ~pll_status_i);
            check_bit("led_glitch_o", led_glitch_o, 1'b0);
         end
      end
   end

   // Host bus model tasks start and end on a falling edge
   task automatic set_address(reg_addr_t addr);
      usb_addr_i = addr;
      usb_cen_i  = 1'b0;
      usb_alen_i = 1'b0;
      repeat (HOLD) @(negedge clk_usb_buf);
      usb_alen_i = 1'b1;
      repeat (HOLD) @(negedge clk_usb_buf);
   endtask

   task automatic write_byte(reg_data_t data);
      usb_data_i = data;
      usb_wrn_i  = 1'b0;
      repeat (HOLD) @(negedge clk_usb_buf);
      usb_wrn_i = 1'b1;
      repeat (HOLD) @(negedge clk_usb_buf);
   endtask

   task automatic read_byte(output reg_data_t data);
      int waited;
      waited    = 0;
      check_bit("usb_data_oe_o", usb_data_oe_o, 1'b0);  // Bus not driven between reads
      usb_rdn_i = 1'b0;
      do begin
         @(posedge clk_usb_buf);
         #1;
         waited++;
      end while (!usb_data_oe_o && waited < WAIT_LIMIT);
      if (!usb_data_oe_o) begin
         report_timeout("usb_data_oe_o rising during a read");
      end
      repeat (3) @(posedge clk_usb_buf);  // Read data settles after three clocks
      #1;
      check_bit("usb_data_oe_o", usb_data_oe_o, 1'b1);
      data = usb_data_o;
      repeat (HOLD - 3) @(negedge clk_usb_buf);
      usb_rdn_i = 1'b1;
      repeat (HOLD) @(negedge clk_usb_buf);
   endtask

   task automatic end_cycle();
      usb_cen_i = 1'b1;
      repeat (HOLD) @(negedge clk_usb_buf);
   endtask

   task automatic host_write(reg_addr_t addr, reg_data_t data);
      set_address(addr);
      write_byte(data);
      end_cycle();
   endtask

   task automatic host_read(reg_addr_t addr, output reg_data_t data);
      set_address(addr);
      read_byte(data);
      end_cycle();
   endtask

   task automatic write_target(reg_data_t ctrl, reg_data_t out);
      check_en = 1'b0;
      host_write(`TARGET_CTRL_ADDR, ctrl);
      host_write(`TARGET_OUT_ADDR, out);
      ctrl_img = ctrl & 8'h03;  // Power-off and AVR enable only
      out_img  = out & 8'h77;
      check_en = 1'b1;
   endtask

   task automatic wait_led_toggle(output int gap);
      logic start;
      start = led_adc_o;
      gap   = 0;
      do begin
         @(posedge clk_usb_buf);
         #1;
         gap++;
      end while (led_adc_o === start && gap < WAIT_LIMIT);
      if (led_adc_o === start) begin
         report_timeout("a toggle of led_adc_o");
      end
   endtask

   initial begin
      reg_data_t rd;
      reg_data_t lo;
      reg_data_t hi;
      reg_data_t wdata;
      reg_data_t period;
      int        src;
      int        gap;
      logic      flash_exp;
      void'($urandom(SEED));
      rst_i         = 1'b1;
      usb_addr_i    = '0;
      usb_data_i    = '0;
      usb_rdn_i     = 1'b1;
      usb_wrn_i     = 1'b1;
      usb_cen_i     = 1'b1;
      usb_alen_i    = 1'b1;
      avr_rst_i     = 1'b0;
      sam_mosi_i    = 1'b0;
      sam_spck_i    = 1'b0;
      target_miso_i = 1'b0;
      error_flags_i = '0;
      pll_status_i  = 1'b1;
      ctrl_img      = 8'h01;  // Target comes up unpowered
      out_img       = 8'h00;
      flags_img     = '0;
      check_en      = 1'b0;
      repeat (5) @(negedge clk_usb_buf);
      rst_i    = 1'b0;
      check_en = 1'b1;

      host_read(`TARGET_CTRL_ADDR, rd);
      check_data("TARGET_CTRL after reset", rd, 8'h01);
      host_read(`TARGET_OUT_ADDR, rd);
      check_data("TARGET_OUT after reset", rd, 8'h00);

      for (int i = 0; i < 16; i++) begin
         wdata = reg_data_t'($urandom);
         if (i == 0) begin
            wdata = 8'h03;  // Power-off with AVR programming on
         end
         write_target(wdata, reg_data_t'($urandom));
         host_read(`TARGET_CTRL_ADDR, rd);
         check_data("TARGET_CTRL", rd, ctrl_img);
         host_read(`TARGET_OUT_ADDR, rd);
         check_data("TARGET_OUT", rd, out_img);
         repeat (HOLD) begin
            @(negedge clk_usb_buf);
            {avr_rst_i, sam_mosi_i, sam_spck_i, target_miso_i} = 4'($urandom);
         end
      end
      host_read(8'h05, rd);
      check_data("unused address", rd, 8'h00);

      lo = reg_data_t'($urandom);
      hi = reg_data_t'($urandom);
      set_address(`FLASH_PERIOD_ADDR);
      write_byte(lo);
      write_byte(hi);
      end_cycle();
      set_address(`FLASH_PERIOD_ADDR);
      read_byte(rd);
      check_data("FLASH_PERIOD low byte", rd, lo);
      read_byte(rd);
      check_data("FLASH_PERIOD high byte", rd, hi);
      end_cycle();

      check_en = 1'b0;
      period   = reg_data_t'(4 + $urandom % 8);
      set_address(`FLASH_PERIOD_ADDR);
      write_byte(period);
      write_byte(8'h00);
      end_cycle();
      repeat (2) begin
         src           = $urandom % `NUM_ERR_SRC;
         error_flags_i = err_flags_t'(1 << src);
         @(negedge clk_usb_buf);
         error_flags_i = '0;
         flags_img     = expected_status(flags_img, '0, err_flags_t'(1 << src));
      end

      flash_exp = 1'b0;  // Flash starts low when the first flag sets
      check_bit("led_adc_o", led_adc_o, flash_exp);
      check_bit("led_glitch_o", led_glitch_o, flash_exp);
      wait_led_toggle(gap);  // First toggle only lines up the phase
      repeat (3) begin
         flash_exp = ~flash_exp;
         check_bit("led_glitch_o", led_glitch_o, flash_exp);
         wait_led_toggle(gap);
         check_data("led_adc_o toggle interval", reg_data_t'(gap), period);
      end

      @(negedge clk_usb_buf);
      host_read(`ERROR_STATUS_ADDR, rd);
      check_data("ERROR_STATUS", rd, reg_data_t'(flags_img));
      host_write(`ERROR_STATUS_ADDR, 8'h07);
      flags_img = expected_status(flags_img, 3'b111, '0);
      host_read(`ERROR_STATUS_ADDR, rd);
      check_data("ERROR_STATUS after clear", rd, reg_data_t'(flags_img));
      check_en = 1'b1;
      repeat (4) begin
         pll_status_i = ~pll_status_i;
         repeat (HOLD) @(negedge clk_usb_buf);
      end

      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

// File: sources.f
+incdir+.
husky_pkg.sv
reg_bus_if.sv
usb_reg_main.sv
reg_target_io.sv
reg_status_led.sv
cw_husky_top.sv
tb_cw_husky_top.sv

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_cw_husky_top \
   -f sources.f -o sim_tb_cw_husky_top

./obj_dir/sim_tb_cw_husky_top | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
   echo "Testbench reported a failure, see sim.log"
   exit 1
fi
echo "No failure found in sim.log"
